//--- sim.f
+incdir+src
src/rv_decode_pkg.sv
src/base_decoder.sv
src/compressed_decoder.sv
src/decode_result.sv
src/rv_decoder_top.sv
tests/rv_decoder_asserts.sv
tests/rv_decoder_tb.sv

//--- src/base_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defines.svh"

module base_decoder (
    input  rv_decode_pkg::word_t       instr_q,
    output rv_decode_pkg::dec_fields_t base_fields
);

    logic [2:0]                 funct3;
    logic                       alt;
    rv_decode_pkg::word_t       imm_i;
    rv_decode_pkg::word_t       imm_s;
    rv_decode_pkg::word_t       imm_b;
    rv_decode_pkg::word_t       imm_u;
    rv_decode_pkg::word_t       imm_j;
    rv_decode_pkg::word_t       shamt;
    rv_decode_pkg::dec_fields_t f;

    assign funct3 = instr_q[14:12];
    assign alt    = instr_q[30];    // sub / sra select.

    // ********************
    // immediate formats.
    // ********************
    assign imm_i = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
    assign imm_b = {{19{instr_q[31]}}, instr_q[31], instr_q[7], instr_q[30:25],
                    instr_q[11:8], 1'b0};
    assign imm_u = {instr_q[31:12], 12'b0};
    assign imm_j = {{11{instr_q[31]}}, instr_q[31], instr_q[19:12], instr_q[20],
                    instr_q[30:21], 1'b0};
    assign shamt = {27'b0, instr_q[24:20]};

    always_comb begin
        f    = '0;
        f.op = rv_decode_pkg::op_invalid;
        case (instr_q[6:0])
            `RV_OPC_LUI, `RV_OPC_AUIPC: begin
                f.op      = (instr_q[5]) ? rv_decode_pkg::op_lui : rv_decode_pkg::op_auipc;
                f.rd      = instr_q[11:7];
                f.imm     = imm_u;
                f.has_imm = 1'b1;
            end
            `RV_OPC_JAL: begin
                f.op      = rv_decode_pkg::op_jal;
                f.rd      = instr_q[11:7];
                f.imm     = imm_j;
                f.has_imm = 1'b1;
            end
            `RV_OPC_JALR: begin
                f.op      = rv_decode_pkg::op_jalr;
                f.rd      = instr_q[11:7];
                f.rs1     = instr_q[19:15];
                f.imm     = imm_i;
                f.has_imm = 1'b1;
            end
            `RV_OPC_BRANCH: begin
                case (funct3)
                    3'b000:  f.op = rv_decode_pkg::op_beq;
                    3'b001:  f.op = rv_decode_pkg::op_bne;
                    3'b100:  f.op = rv_decode_pkg::op_blt;
                    3'b101:  f.op = rv_decode_pkg::op_bge;
                    3'b110:  f.op = rv_decode_pkg::op_bltu;
                    3'b111:  f.op = rv_decode_pkg::op_bgeu;
                    default: f.op = rv_decode_pkg::op_invalid;
                endcase
                f.rs1     = instr_q[19:15];
                f.rs2     = instr_q[24:20];
                f.imm     = imm_b;
                f.has_imm = 1'b1;
            end
            `RV_OPC_LOAD: begin
                case (funct3)
                    3'b000:  f.op = rv_decode_pkg::op_lb;
                    3'b001:  f.op = rv_decode_pkg::op_lh;
                    3'b010:  f.op = rv_decode_pkg::op_lw;
                    3'b100:  f.op = rv_decode_pkg::op_lbu;
                    3'b101:  f.op = rv_decode_pkg::op_lhu;
                    default: f.op = rv_decode_pkg::op_invalid;
                endcase
                f.rd      = instr_q[11:7];
                f.rs1     = instr_q[19:15];
                f.imm     = imm_i;
                f.has_imm = 1'b1;
            end
            `RV_OPC_STORE: begin
                case (funct3)
                    3'b000:  f.op = rv_decode_pkg::op_sb;
                    3'b001:  f.op = rv_decode_pkg::op_sh;
                    3'b010:  f.op = rv_decode_pkg::op_sw;
                    default: f.op = rv_decode_pkg::op_invalid;
                endcase
                f.rs1     = instr_q[19:15];
                f.rs2     = instr_q[24:20];
                f.imm     = imm_s;
                f.has_imm = 1'b1;
            end
            `RV_OPC_OPIMM, `RV_OPC_OP: begin
                case (funct3)
                    3'b000:  f.op = (alt && instr_q[5]) ? rv_decode_pkg::op_sub
                                                        : rv_decode_pkg::op_add;
                    3'b001:  f.op = rv_decode_pkg::op_sll;
                    3'b010:  f.op = rv_decode_pkg::op_slt;
                    3'b011:  f.op = rv_decode_pkg::op_sltu;
                    3'b100:  f.op = rv_decode_pkg::op_xor;
                    3'b101:  f.op = (alt) ? rv_decode_pkg::op_sra : rv_decode_pkg::op_srl;
                    3'b110:  f.op = rv_decode_pkg::op_or;
                    default: f.op = rv_decode_pkg::op_and;
                endcase
                f.rd  = instr_q[11:7];
                f.rs1 = instr_q[19:15];
                if (instr_q[5]) begin   // register form.
                    f.rs2 = instr_q[24:20];
                end else begin
                    f.imm     = (funct3[1:0] == 2'b01) ? shamt : imm_i;
                    f.has_imm = 1'b1;
                end
            end
            default: f.op = rv_decode_pkg::op_invalid;
        endcase
        // anything unrecognised comes out clean.
        if (f.op == rv_decode_pkg::op_invalid) begin
            f    = '0;
            f.op = rv_decode_pkg::op_invalid;
        end
    end

    assign base_fields = f;

endmodule

`default_nettype wire

//--- src/compressed_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defines.svh"

module compressed_decoder (
    input  rv_decode_pkg::word_t       instr_q,
    output rv_decode_pkg::dec_fields_t c_fields
);

    rv_decode_pkg::reg_idx_t    rd_c;
    rv_decode_pkg::reg_idx_t    rd_p;
    rv_decode_pkg::reg_idx_t    rs2_p;
    rv_decode_pkg::word_t       imm_ci;
    rv_decode_pkg::word_t       imm_cj;
    rv_decode_pkg::word_t       imm_cb;
    rv_decode_pkg::word_t       imm_16sp;
    rv_decode_pkg::word_t       imm_lui;
    rv_decode_pkg::word_t       shamt;
    rv_decode_pkg::dec_fields_t f;

    assign rd_c  = instr_q[11:7];
    assign rd_p  = `RV_RVC_REG_BASE + {2'b00, instr_q[9:7]};
    assign rs2_p = `RV_RVC_REG_BASE + {2'b00, instr_q[4:2]};

    // ********************
    // rvc immediates.
    // ********************
    assign imm_ci   = {{27{instr_q[12]}}, instr_q[6:2]};
    assign imm_cj   = {{21{instr_q[12]}}, instr_q[8], instr_q[10:9], instr_q[6], instr_q[7],
                       instr_q[2], instr_q[11], instr_q[5:3], 1'b0};
    assign imm_cb   = {{24{instr_q[12]}}, instr_q[6:5], instr_q[2], instr_q[11:10],
                       instr_q[4:3], 1'b0};
    assign imm_16sp = {{23{instr_q[12]}}, instr_q[4:3], instr_q[5], instr_q[2], instr_q[6],
                       4'b0};
    assign imm_lui  = {{15{instr_q[12]}}, instr_q[6:2], 12'b0};
    assign shamt    = {26'b0, instr_q[12], instr_q[6:2]};

    always_comb begin
        f    = '0;
        f.op = rv_decode_pkg::op_invalid;
        if (instr_q[1:0] == `RV_QUAD_C1) begin
            f.has_imm = 1'b1;
            case (instr_q[15:13])
                3'b000: begin           // c.addi
                    f.op  = rv_decode_pkg::op_add;
                    f.rd  = rd_c;
                    f.rs1 = rd_c;
                    f.imm = imm_ci;
                end
                3'b001, 3'b101: begin   // c.jal links x1, c.j does not.
                    f.op  = rv_decode_pkg::op_jal_c;
                    f.rd  = (instr_q[15]) ? 5'd0 : 5'd1;
                    f.imm = imm_cj;
                end
                3'b010: begin           // c.li
                    f.op  = rv_decode_pkg::op_add;
                    f.rd  = rd_c;
                    f.imm = imm_ci;
                end
                3'b011: begin
                    if (rd_c == 5'd2) begin
                        f.op  = rv_decode_pkg::op_add;
                        f.rd  = 5'd2;
                        f.rs1 = 5'd2;
                        f.imm = imm_16sp;
                    end else begin
                        f.op  = rv_decode_pkg::op_lui;
                        f.rd  = rd_c;
                        f.imm = imm_lui;
                    end
                end
                3'b100: begin
                    f.rd  = rd_p;
                    f.rs1 = rd_p;
                    case (instr_q[11:10])
                        2'b00: begin
                            f.op  = rv_decode_pkg::op_srl;
                            f.imm = shamt;
                        end
                        2'b01: begin
                            f.op  = rv_decode_pkg::op_sra;
                            f.imm = shamt;
                        end
                        2'b10: begin
                            f.op  = rv_decode_pkg::op_and;
                            f.imm = imm_ci;
                        end
                        default: begin  // register-register group.
                            f.rs2     = rs2_p;
                            f.has_imm = 1'b0;
                            case (instr_q[6:5])
                                2'b00:   f.op = rv_decode_pkg::op_sub;
                                2'b01:   f.op = rv_decode_pkg::op_xor;
                                2'b10:   f.op = rv_decode_pkg::op_or;
                                default: f.op = rv_decode_pkg::op_and;
                            endcase
                        end
                    endcase
                end
                default: begin          // c.beqz / c.bnez.
                    f.op  = (instr_q[13]) ? rv_decode_pkg::op_bne : rv_decode_pkg::op_beq;
                    f.rs1 = rd_p;
                    f.imm = imm_cb;
                end
            endcase
        end
    end

    assign c_fields = f;

endmodule

`default_nettype wire

//--- src/decode_result.sv
`timescale 1ns/1ps
`default_nettype none

module decode_result (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  rv_decode_pkg::word_t       instr,
    input  rv_decode_pkg::dec_fields_t base_fields,
    input  rv_decode_pkg::dec_fields_t c_fields,
    output rv_decode_pkg::word_t       instr_q,
    output logic                       ack,
    output rv_decode_pkg::dec_fields_t fields
);

    rv_decode_pkg::hs_state_e   state;
    rv_decode_pkg::dec_fields_t sel_fields;

    // low bits 11 mean a full-width word.
    assign sel_fields = (instr_q[1:0] == 2'b11) ? base_fields : c_fields;
    assign ack        = (state == rv_decode_pkg::st_done);

    always_ff @(posedge clk) begin
        if (state == rv_decode_pkg::st_idle && req) begin
            instr_q <= instr;
        end
    end

    // ********************
    // req/ack handshake.
    // ********************
    always_ff @(posedge clk) begin
        if (!rst) begin
            state  <= rv_decode_pkg::st_idle;
            fields <= '{op: rv_decode_pkg::op_invalid, default: '0};
        end else begin
            case (state)
                rv_decode_pkg::st_idle: begin
                    if (req) begin
                        state <= rv_decode_pkg::st_decode;
                    end
                end
                rv_decode_pkg::st_decode: begin
                    fields <= sel_fields;   // held until the next decode.
                    state  <= rv_decode_pkg::st_done;
                end
                rv_decode_pkg::st_done: begin
                    if (!req) begin
                        state <= rv_decode_pkg::st_idle;
                    end
                end
                default: state <= rv_decode_pkg::st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/rv_decode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// ********************
// widths
// ********************

`define RV_XLEN   32    // instruction and data width.
`define RV_REG_W  5     // register index.
`define RV_OP_W   5     // decoded operation code.

// ********************
// major opcodes
// ********************

`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_OPIMM   7'b0010011
`define RV_OPC_OP      7'b0110011

// ********************
// compressed
// ********************

`define RV_QUAD_C1       2'b01   // quadrant 1 in bits 1:0.
`define RV_RVC_REG_BASE  5'd8    // x8, first register reachable by 3-bit fields.

`endif

//--- src/rv_decode_pkg.sv
`default_nettype none

`include "rv_decode_defines.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0]  word_t;
    typedef logic [`RV_REG_W-1:0] reg_idx_t;

    // encoding order kept from the original decoder.
    typedef enum logic [`RV_OP_W-1:0] {
        op_add = 5'd0,
        op_and,
        op_or,
        op_sll,
        op_srl,
        op_slt,
        op_sltu,
        op_sra,
        op_sub,
        op_xor,
        op_beq,
        op_bge,
        op_bne,
        op_bgeu,
        op_lui,
        op_auipc,
        op_jal,
        op_jalr,
        op_lb,
        op_lh,
        op_lw,
        op_lbu,
        op_lhu,
        op_sb,
        op_sh,
        op_sw,
        op_blt,
        op_bltu,
        op_jal_c,       // jump, link is pc + 2.
        op_invalid = '1
    } op_e;

    typedef enum logic [1:0] {
        st_idle,
        st_decode,
        st_done
    } hs_state_e;

    typedef struct packed {
        op_e      op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        logic     has_imm;
    } dec_fields_t;

endpackage

`default_nettype wire

//--- src/rv_decoder_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       req,
    input  rv_decode_pkg::word_t       instr,
    output logic                       ack,
    output rv_decode_pkg::dec_fields_t fields
);

    rv_decode_pkg::word_t       instr_q;
    rv_decode_pkg::dec_fields_t base_fields;
    rv_decode_pkg::dec_fields_t c_fields;

    decode_result decode_result_i (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .instr       (instr),
        .base_fields (base_fields),
        .c_fields    (c_fields),
        .instr_q     (instr_q),
        .ack         (ack),
        .fields      (fields)
    );

    base_decoder base_decoder_i (
        .instr_q     (instr_q),
        .base_fields (base_fields)
    );

    compressed_decoder compressed_decoder_i (
        .instr_q  (instr_q),
        .c_fields (c_fields)
    );

endmodule

`default_nettype wire

//--- tests/rv_decoder_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module rv_decoder_asserts (
    input logic                       clk,
    input logic                       rst,
    input logic                       req,
    input logic                       ack,
    input rv_decode_pkg::dec_fields_t fields
);

    int failures = 0;

    // ********************
    // handshake rules.
    // ********************
    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!rst)
        $rose(ack) |-> $past(req))
        else begin
            $error("ack rose while req was low");
            failures++;
        end

    ack_fall_needs_req_low: assert property (@(posedge clk) disable iff (!rst)
        $fell(ack) |-> !$past(req))
        else begin
            $error("ack fell before req was sampled low");
            failures++;
        end

    fields_hold: assert property (@(posedge clk) disable iff (!rst)
        (ack && $past(ack)) |-> $stable(fields))
        else begin
            $error("fields changed while ack was high");
            failures++;
        end

endmodule

bind rv_decoder_top rv_decoder_asserts rv_decoder_asserts_i (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .ack    (ack),
    .fields (fields)
);

`default_nettype wire

//--- tests/rv_decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_defines.svh"

module rv_decoder_tb;

    localparam int n_per_opcode = 300;
    localparam int n_rvc        = 300;
    localparam int n_invalid    = 151;
    localparam int n_timing     = 50;
    localparam int n_total      = 9 * n_per_opcode + n_rvc + n_invalid + n_timing;
    localparam int cycle_limit  = n_total * 8 + 50;

    localparam logic [6:0] opcodes [9] = '{`RV_OPC_LUI, `RV_OPC_AUIPC, `RV_OPC_JAL,
        `RV_OPC_JALR, `RV_OPC_BRANCH, `RV_OPC_LOAD, `RV_OPC_STORE, `RV_OPC_OPIMM,
        `RV_OPC_OP};

    logic                       clk;
    logic                       rst;
    logic                       req;
    rv_decode_pkg::word_t       instr;
    logic                       ack;
    rv_decode_pkg::dec_fields_t fields;

    int checks;
    int errors;
    int mark_checks;
    int mark_errors;
    int cycle_count;

    rv_decoder_top rv_decoder_top_i (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .instr  (instr),
        .ack    (ack),
        .fields (fields)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ********************
    // reference model
    // ********************
    function automatic rv_decode_pkg::word_t sext(input rv_decode_pkg::word_t value,
                                                  input int top);
        rv_decode_pkg::word_t r;
        r = value;
        for (int i = top + 1; i < 32; i++) begin
            r[i] = value[top];
        end
        return r;
    endfunction

    function automatic rv_decode_pkg::dec_fields_t make_fields(
        input rv_decode_pkg::op_e op, input rv_decode_pkg::reg_idx_t rd,
        input rv_decode_pkg::reg_idx_t rs1, input rv_decode_pkg::reg_idx_t rs2,
        input rv_decode_pkg::word_t imm, input logic has_imm);
        rv_decode_pkg::dec_fields_t f;
        f    = '0;
        f.op = op;
        if (op != rv_decode_pkg::op_invalid) begin   // invalid keeps all else zero.
            f.rd      = rd;
            f.rs1     = rs1;
            f.rs2     = rs2;
            f.imm     = imm;
            f.has_imm = has_imm;
        end
        return f;
    endfunction

    function automatic rv_decode_pkg::dec_fields_t base_model(input rv_decode_pkg::word_t w);
        rv_decode_pkg::op_e      op;
        rv_decode_pkg::reg_idx_t rd;
        rv_decode_pkg::reg_idx_t rs1;
        rv_decode_pkg::reg_idx_t rs2;
        logic [2:0]              f3;
        rd  = w[11:7];
        rs1 = w[19:15];
        rs2 = w[24:20];
        f3  = w[14:12];
        op  = rv_decode_pkg::op_invalid;
        case (w[6:0])
            `RV_OPC_LUI:
                return make_fields(rv_decode_pkg::op_lui, rd, 0, 0, {w[31:12], 12'b0}, 1'b1);
            `RV_OPC_AUIPC:
                return make_fields(rv_decode_pkg::op_auipc, rd, 0, 0, {w[31:12], 12'b0}, 1'b1);
            `RV_OPC_JAL:
                return make_fields(rv_decode_pkg::op_jal, rd, 0, 0,
                                   sext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 20), 1'b1);
            `RV_OPC_JALR:
                return make_fields(rv_decode_pkg::op_jalr, rd, rs1, 0, sext(w[31:20], 11), 1'b1);
            `RV_OPC_BRANCH: begin
                case (f3)
                    3'd0: op = rv_decode_pkg::op_beq;
                    3'd1: op = rv_decode_pkg::op_bne;
                    3'd4: op = rv_decode_pkg::op_blt;
                    3'd5: op = rv_decode_pkg::op_bge;
                    3'd6: op = rv_decode_pkg::op_bltu;
                    3'd7: op = rv_decode_pkg::op_bgeu;
                    default: op = rv_decode_pkg::op_invalid;
                endcase
                return make_fields(op, 0, rs1, rs2,
                                   sext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 12), 1'b1);
            end
            `RV_OPC_LOAD: begin
                case (f3)
                    3'd0: op = rv_decode_pkg::op_lb;
                    3'd1: op = rv_decode_pkg::op_lh;
                    3'd2: op = rv_decode_pkg::op_lw;
                    3'd4: op = rv_decode_pkg::op_lbu;
                    3'd5: op = rv_decode_pkg::op_lhu;
                    default: op = rv_decode_pkg::op_invalid;
                endcase
                return make_fields(op, rd, rs1, 0, sext(w[31:20], 11), 1'b1);
            end
            `RV_OPC_STORE: begin
                case (f3)
                    3'd0: op = rv_decode_pkg::op_sb;
                    3'd1: op = rv_decode_pkg::op_sh;
                    3'd2: op = rv_decode_pkg::op_sw;
                    default: op = rv_decode_pkg::op_invalid;
                endcase
                return make_fields(op, 0, rs1, rs2, sext({w[31:25], w[11:7]}, 11), 1'b1);
            end
            `RV_OPC_OPIMM, `RV_OPC_OP: begin
                case (f3)
                    3'd0: op = (w[6:0] == `RV_OPC_OP && w[30]) ? rv_decode_pkg::op_sub
                                                               : rv_decode_pkg::op_add;
                    3'd1: op = rv_decode_pkg::op_sll;
                    3'd2: op = rv_decode_pkg::op_slt;
                    3'd3: op = rv_decode_pkg::op_sltu;
                    3'd4: op = rv_decode_pkg::op_xor;
                    3'd5: op = (w[30]) ? rv_decode_pkg::op_sra : rv_decode_pkg::op_srl;
                    3'd6: op = rv_decode_pkg::op_or;
                    default: op = rv_decode_pkg::op_and;
                endcase
                if (w[6:0] == `RV_OPC_OP) begin
                    return make_fields(op, rd, rs1, rs2, 0, 1'b0);
                end
                if (f3 == 3'd1 || f3 == 3'd5) begin   // shamt, no sign.
                    return make_fields(op, rd, rs1, 0, w[24:20], 1'b1);
                end
                return make_fields(op, rd, rs1, 0, sext(w[31:20], 11), 1'b1);
            end
            default: op = rv_decode_pkg::op_invalid;
        endcase
        return make_fields(rv_decode_pkg::op_invalid, 0, 0, 0, 0, 1'b0);
    endfunction

    function automatic rv_decode_pkg::dec_fields_t rvc_model(input rv_decode_pkg::word_t w);
        rv_decode_pkg::op_e      op;
        rv_decode_pkg::reg_idx_t rd;
        rv_decode_pkg::reg_idx_t rdp;
        rv_decode_pkg::reg_idx_t rs2p;
        rv_decode_pkg::word_t    imm6;
        rv_decode_pkg::word_t    cj;
        rv_decode_pkg::word_t    cb;
        rd   = w[11:7];
        rdp  = `RV_RVC_REG_BASE + w[9:7];
        rs2p = `RV_RVC_REG_BASE + w[4:2];
        imm6 = sext({w[12], w[6:2]}, 5);
        cj   = sext({w[12], w[8], w[10:9], w[6], w[7], w[2], w[11], w[5:3], 1'b0}, 11);
        cb   = sext({w[12], w[6:5], w[2], w[11:10], w[4:3], 1'b0}, 8);
        case (w[15:13])
            3'd0: return make_fields(rv_decode_pkg::op_add, rd, rd, 0, imm6, 1'b1);
            3'd1: return make_fields(rv_decode_pkg::op_jal_c, 1, 0, 0, cj, 1'b1);
            3'd2: return make_fields(rv_decode_pkg::op_add, rd, 0, 0, imm6, 1'b1);
            3'd3: begin
                if (rd == 5'd2) begin   // c.addi16sp.
                    return make_fields(rv_decode_pkg::op_add, 2, 2, 0,
                                       sext({w[12], w[4:3], w[5], w[2], w[6], 4'b0}, 9), 1'b1);
                end
                return make_fields(rv_decode_pkg::op_lui, rd, 0, 0,
                                   sext({w[12], w[6:2], 12'b0}, 17), 1'b1);
            end
            3'd4: begin
                case (w[11:10])
                    2'd0: return make_fields(rv_decode_pkg::op_srl, rdp, rdp, 0,
                                             {w[12], w[6:2]}, 1'b1);
                    2'd1: return make_fields(rv_decode_pkg::op_sra, rdp, rdp, 0,
                                             {w[12], w[6:2]}, 1'b1);
                    2'd2: return make_fields(rv_decode_pkg::op_and, rdp, rdp, 0, imm6, 1'b1);
                    default: begin
                        case (w[6:5])
                            2'd0: op = rv_decode_pkg::op_sub;
                            2'd1: op = rv_decode_pkg::op_xor;
                            2'd2: op = rv_decode_pkg::op_or;
                            default: op = rv_decode_pkg::op_and;
                        endcase
                        return make_fields(op, rdp, rdp, rs2p, 0, 1'b0);
                    end
                endcase
            end
            3'd5: return make_fields(rv_decode_pkg::op_jal_c, 0, 0, 0, cj, 1'b1);
            3'd6: return make_fields(rv_decode_pkg::op_beq, 0, rdp, 0, cb, 1'b1);
            default: return make_fields(rv_decode_pkg::op_bne, 0, rdp, 0, cb, 1'b1);
        endcase
    endfunction

    function automatic rv_decode_pkg::dec_fields_t expected_fields(
        input rv_decode_pkg::word_t w);
        if (w[1:0] == 2'b11) begin
            return base_model(w);
        end
        if (w[1:0] == `RV_QUAD_C1) begin
            return rvc_model(w);
        end
        return make_fields(rv_decode_pkg::op_invalid, 0, 0, 0, 0, 1'b0);
    endfunction

    function automatic string show_fields(input rv_decode_pkg::dec_fields_t f);
        return $sformatf("{op %0d rd %0d rs1 %0d rs2 %0d imm %h has_imm %b}",
                         f.op, f.rd, f.rs1, f.rs2, f.imm, f.has_imm);
    endfunction

    // ********************
    // stimulus words
    // ********************
    function automatic logic is_kept_opcode(input logic [6:0] opc);
        for (int k = 0; k < 9; k++) begin
            if (opcodes[k] == opc) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic rv_decode_pkg::word_t base_word(input logic [6:0] opc);
        rv_decode_pkg::word_t w;
        w      = $urandom();
        w[6:0] = opc;
        if (opc == `RV_OPC_JALR) begin
            w[14:12] = 3'd0;
        end
        // redraw funct3 until it is a listed one.
        while ((opc == `RV_OPC_BRANCH && w[14:13] == 2'b01) ||
               (opc == `RV_OPC_LOAD && (w[14:12] == 3'd3 || w[14:13] == 2'b11)) ||
               (opc == `RV_OPC_STORE && w[14:12] > 3'd2)) begin
            w[14:12] = $urandom();
        end
        return w;
    endfunction

    function automatic rv_decode_pkg::word_t rvc_word();
        rv_decode_pkg::word_t w;
        w      = $urandom();
        w[1:0] = `RV_QUAD_C1;
        if (w[15:13] == 3'b011 && w[31]) begin   // steer half of these to c.addi16sp.
            w[11:7] = 5'd2;
        end
        return w;
    endfunction

    function automatic rv_decode_pkg::word_t invalid_word();
        rv_decode_pkg::word_t w;
        w = $urandom();
        case ($urandom_range(0, 4))
            0: begin
                w[1:0] = 2'b11;
                while (is_kept_opcode(w[6:0])) begin
                    w[6:2] = $urandom();
                end
            end
            1: begin
                w[6:0]   = `RV_OPC_BRANCH;
                w[14:13] = 2'b01;
            end
            2: begin
                w[6:0]   = `RV_OPC_LOAD;
                w[14:12] = ($urandom_range(0, 2) == 0) ? 3'd3 : {2'b11, w[12]};
            end
            3: begin
                w[6:0]   = `RV_OPC_STORE;
                w[14:12] = 3'd3 + $urandom_range(0, 4);
            end
            default: w[1:0] = {w[1], 1'b0};   // quadrant 0 or 2.
        endcase
        return w;
    endfunction

    // ********************
    // checks and handshake
    // ********************
    task automatic expect_ok(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            $display("%s", msg);
            errors++;
        end
    endtask

    task automatic run_handshake(input rv_decode_pkg::word_t w,
                                 input rv_decode_pkg::dec_fields_t exp, input int hold);
        rv_decode_pkg::dec_fields_t got;
        int                         waited;
        instr  = w;
        req    = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ack && waited < 10);
        expect_ok(ack === 1'b1 && waited == 2,
                  $sformatf("at %0t ack did not rise 2 cycles after req (waited %0d)",
                            $time, waited));
        got = fields;
        expect_ok(got === exp, $sformatf("mismatch at %0t: instr %h expected %s got %s",
                                         $time, w, show_fields(exp), show_fields(got)));
        repeat (hold) begin
            @(posedge clk);
            #1;
            expect_ok(ack === 1'b1 && fields === got,
                      $sformatf("at %0t ack dropped or fields changed while req was held",
                                $time));
        end
        req    = 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (ack && waited < 10);
        expect_ok(waited == 1 && fields === got,
                  $sformatf("at %0t ack took %0d cycles to drop or fields changed",
                            $time, waited));
    endtask

    task automatic close_test(input string name);
        $display("%s: %0d checks, %0d failed", name, checks - mark_checks,
                 errors - mark_errors);
        mark_checks = checks;
        mark_errors = errors;
    endtask

    initial begin
        rv_decode_pkg::word_t       w;
        rv_decode_pkg::dec_fields_t bad;
        int                         assert_fails;
        checks      = 0;
        errors      = 0;
        mark_checks = 0;
        mark_errors = 0;
        rst         = 1'b0;
        req         = 1'b0;
        instr       = '0;
        void'($urandom(58));
        bad = make_fields(rv_decode_pkg::op_invalid, 0, 0, 0, 0, 1'b0);
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        expect_ok(ack === 1'b0 && fields.op === rv_decode_pkg::op_invalid,
                  $sformatf("mismatch at %0t: after reset ack %b op %0d, expected ack 0 op %0d",
                            $time, ack, fields.op, rv_decode_pkg::op_invalid));
        close_test("reset state");

        for (int k = 0; k < 9; k++) begin
            for (int n = 0; n < n_per_opcode; n++) begin
                w = base_word(opcodes[k]);
                run_handshake(w, expected_fields(w), 0);
            end
        end
        close_test("rv32i random words");

        for (int n = 0; n < n_rvc; n++) begin
            w = rvc_word();
            run_handshake(w, expected_fields(w), 0);
        end
        close_test("compressed random words");

        run_handshake('0, bad, 0);
        for (int n = 1; n < n_invalid; n++) begin
            run_handshake(invalid_word(), bad, 0);
        end
        close_test("invalid words");

        for (int n = 0; n < n_timing; n++) begin
            w = ($urandom_range(0, 1)) ? rvc_word() : base_word(opcodes[$urandom_range(0, 8)]);
            run_handshake(w, expected_fields(w), $urandom_range(0, 5));
        end
        close_test("handshake timing");

        assert_fails = rv_decoder_top_i.rv_decoder_asserts_i.failures;
        $display("checks passed %0d, failed %0d, assertion failures %0d",
                 checks - errors, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
